// File: mext_unit.f
+incdir+source
source/mext_pkg.sv
source/mext_divu.sv
source/mext_div.sv
source/mext_mul.sv
source/mext_unit.sv
test/mext_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the mext_unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module mext_unit_tb -f mext_unit.f -o mext_unit_sim

./obj_dir/mext_unit_sim | tee sim.log

if grep -q '^>>> PASS$' sim.log; then
  exit 0
else
  echo "Simulation did not pass, see sim.log"
  exit 1
fi

// File: test/mext_unit_tb.sv
`timescale 1ns/1ps

`include "mext_macros.svh"

module mext_unit_tb;

  localparam int XLEN         = `MEXT_XLEN;
  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 10;
  // Each random round runs all eight funct3 values
  localparam int RAND_ROUNDS  = 8;
  // Divide by zero 4, overflow 2, sign rules 8, operand latching 2
  localparam int DIRECTED_OPS = 16;
  localparam int TOTAL_OPS    = 8 * RAND_ROUNDS + DIRECTED_OPS;
  // A full division plus launch and handshake edges per op
  localparam int TIMEOUT_CYCLES = TOTAL_OPS * (`MEXT_DIV_CYCLES + 4) + RESET_CYCLES;
  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic               clk;
  logic               rst_n;
  logic               en;
  logic [XLEN-1:0]    rs1;
  logic [XLEN-1:0]    rs2;
  mext_pkg::mext_op_u op;
  logic               busy;
  logic [XLEN-1:0]    result;

  logic [31:0] lcg_state;
  int          error_count = 0;
  int          done_count = 0;
  int          cycle_count = 0;

  // Checker copy of the launched op
  logic               pending;
  mext_pkg::mext_op_u op_seen;
  logic [XLEN-1:0]    a_seen;
  logic [XLEN-1:0]    b_seen;
  logic [XLEN-1:0]    exp_result;
  int                 exp_busy;
  int                 busy_cycles;

  mext_unit mext_unit_i (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (en),
    .rs1   (rs1),
    .rs2   (rs2),
    .op    (op),
    .busy  (busy),
    .result(result)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  // Classic 32-bit LCG, full period modulo 2^32
  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic next_word(output logic [XLEN-1:0] word);
    lcg_state = lcg_step(lcg_state);
    word = lcg_state;
  endtask

  // Expected result by the RISC-V M rules, in double-width arithmetic
  function automatic logic [XLEN-1:0] ref_result(input mext_pkg::mext_op_u f3,
                                                 input logic [XLEN-1:0] a,
                                                 input logic [XLEN-1:0] b);
    logic signed [2*XLEN-1:0] sa;
    logic signed [2*XLEN-1:0] sb;
    logic [2*XLEN-1:0]        ua;
    logic [2*XLEN-1:0]        ub;
    logic [2*XLEN-1:0]        wide;
    logic                     ovf;
    sa   = {{XLEN{a[XLEN-1]}}, a};
    sb   = {{XLEN{b[XLEN-1]}}, b};
    ua   = {{XLEN{1'b0}}, a};
    ub   = {{XLEN{1'b0}}, b};
    ovf  = (a == MOST_NEG) && (b == '1);
    wide = '0;
    case (f3.raw)
      // MUL, MULH, MULHSU, MULHU
      3'd0: wide = sa * sb;
      3'd1: wide = sa * sb;
      3'd2: wide = sa * $signed(ub);
      3'd3: wide = ua * ub;
      // DIV, quotient rounds toward zero
      3'd4: begin
        if (b == '0) begin
          wide = '1;
        end else if (ovf) begin
          wide = ua;
        end else begin
          wide = sa / sb;
        end
      end
      // DIVU
      3'd5: wide = (b == '0) ? '1 : ua / ub;
      // REM takes the sign of the dividend
      3'd6: begin
        if (b == '0) begin
          wide = ua;
        end else if (ovf) begin
          wide = '0;
        end else begin
          wide = sa % sb;
        end
      end
      // REMU
      default: wide = (b == '0) ? ua : ua % ub;
    endcase
    if (f3.raw == 3'd1 || f3.raw == 3'd2 || f3.raw == 3'd3) begin
      return wide[2*XLEN-1:XLEN];
    end
    return wide[XLEN-1:0];
  endfunction

  // Multiply one cycle, zero divisor none, other divides the full count
  function automatic int ref_busy_cycles(input mext_pkg::mext_op_u f3,
                                         input logic [XLEN-1:0] b);
    if (!f3.div.group) begin
      return 1;
    end
    return (b == '0) ? 0 : `MEXT_DIV_CYCLES;
  endfunction

  task automatic check_result(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      error_count++;
      $display("** Error: result funct3=%0h rs1=0x%08h rs2=0x%08h got 0x%08h expected 0x%08h",
               op_seen.raw, a_seen, b_seen, got, exp);
    end
  endtask

  task automatic check_busy_cycles(input int got, input int exp);
    if (got != exp) begin
      error_count++;
      $display("** Error: busy cycles funct3=%0h got 0x%0h expected 0x%0h",
               op_seen.raw, got, exp);
    end
  endtask

  task automatic check_busy(input logic got, input logic exp);
    if (got !== exp) begin
      error_count++;
      $display("** Error: busy got 0x%0h expected 0x%0h", got, exp);
    end
  endtask

  // Launch one op right after a rising edge, then wait for the checker
  task automatic run_op(input logic [2:0] code, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input bit scramble);
    int              target;
    logic [XLEN-1:0] junk;
    target = done_count + 1;
    en     <= 1'b1;
    op.raw <= code;
    rs1    <= a;
    rs2    <= b;
    @(posedge clk);
    en <= 1'b0;
    // Inputs wander while the engine works
    if (scramble) begin
      next_word(junk);
      rs1 <= junk;
      next_word(junk);
      rs2    <= junk;
      op.raw <= ~code;
    end
    while (done_count != target) begin
      @(posedge clk);
    end
  endtask

  // Checker samples pre-edge values, the same ones the DUT sees
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending     = 1'b0;
      busy_cycles = 0;
    end else if (en) begin
      pending     = 1'b1;
      op_seen     = op;
      a_seen      = rs1;
      b_seen      = rs2;
      exp_result  = ref_result(op, rs1, rs2);
      exp_busy    = ref_busy_cycles(op, rs2);
      busy_cycles = 0;
    end else if (pending) begin
      if (busy) begin
        busy_cycles++;
      end else begin
        check_result(result, exp_result);
        check_busy_cycles(busy_cycles, exp_busy);
        pending = 1'b0;
        done_count <= done_count + 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout after %0d cycles, %0d of %0d ops done, %0d errors",
               cycle_count, done_count, TOTAL_OPS, error_count);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    rst_n     = 1'b0;
    en        = 1'b0;
    rs1       = '0;
    rs2       = '0;
    op        = '0;
    lcg_state = 32'd40;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    // Idle after reset
    check_busy(busy, 1'b0);
    for (int round = 0; round < RAND_ROUNDS; round++) begin
      for (int code = 0; code < 8; code++) begin
        next_word(a);
        next_word(b);
        run_op(code[2:0], a, b, 1'b0);
      end
    end
    // Zero divisor for DIV, DIVU, REM, REMU
    for (int code = 4; code < 8; code++) begin
      next_word(a);
      run_op(code[2:0], a, '0, 1'b0);
    end
    // Signed overflow
    run_op(3'd4, MOST_NEG, '1, 1'b0);
    run_op(3'd6, MOST_NEG, '1, 1'b0);
    // All sign combinations of 7 by 2
    for (int s = 0; s < 4; s++) begin
      a = 7;
      b = 2;
      if (s[0]) a = -a;
      if (s[1]) b = -b;
      run_op(3'd4, a, b, 1'b0);
      run_op(3'd6, a, b, 1'b0);
    end
    // Latched operands survive input changes
    next_word(a);
    next_word(b);
    run_op(3'd4, a, b | 1, 1'b1);
    run_op(3'd1, a, b, 1'b1);
    $display("Ops checked: %0d of %0d, errors: %0d", done_count, TOTAL_OPS, error_count);
    if (error_count == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: source/mext_unit.sv
`timescale 1ns/1ps

`include "mext_macros.svh"

module mext_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic [`MEXT_XLEN-1:0] rs1,
  input  logic [`MEXT_XLEN-1:0] rs2,
  input  mext_pkg::mext_op_u    op,
  output logic                  busy,
  output logic [`MEXT_XLEN-1:0] result
);

  // Per-engine strobes
  logic                  mul_en;
  logic                  div_en;
  // Engine status and results
  logic                  mul_busy;
  logic                  div_busy;
  logic [`MEXT_XLEN-1:0] mul_result;
  logic [`MEXT_XLEN-1:0] div_result;
  // Group of the op that last ran, 1 selects the divider
  logic                  group_q;

  // Group bit steers the strobe to one engine
  assign mul_en = en && !op.mul.group;
  assign div_en = en && op.div.group;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      group_q <= 1'b0;
    end else if (en) begin
      group_q <= op.div.group;
    end
  end

  mext_mul mext_mul_i (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (mul_en),
    .rs1   (rs1),
    .rs2   (rs2),
    .op    (op),
    .busy  (mul_busy),
    .result(mul_result)
  );

  mext_div mext_div_i (
    .clk   (clk),
    .rst_n (rst_n),
    .en    (div_en),
    .rs1   (rs1),
    .rs2   (rs2),
    .op    (op),
    .busy  (div_busy),
    .result(div_result)
  );

  assign busy   = mul_busy || div_busy;
  assign result = group_q ? div_result : mul_result;

  // Caller stalls while either engine works
  assert property (@(posedge clk) disable iff (!rst_n) busy |-> !en);

endmodule

// File: source/mext_mul.sv
`timescale 1ns/1ps

`include "mext_macros.svh"

module mext_mul (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic [`MEXT_XLEN-1:0] rs1,
  input  logic [`MEXT_XLEN-1:0] rs2,
  input  mext_pkg::mext_op_u    op,
  output logic                  busy,
  output logic [`MEXT_XLEN-1:0] result
);

  // Per-operand sign extension enables
  logic a_signed;
  logic b_signed;

  // Operands extended by one bit, always multiplied as signed
  logic signed [`MEXT_XLEN:0]     a_ext;
  logic signed [`MEXT_XLEN:0]     b_ext;
  logic signed [2*`MEXT_XLEN+1:0] product;

  // Signedness from the multiply kind
  always_comb begin
    case (op.mul.kind)
      mext_pkg::MEXT_KIND_HSS: {a_signed, b_signed} = 2'b11;
      mext_pkg::MEXT_KIND_HSU: {a_signed, b_signed} = 2'b10;
      mext_pkg::MEXT_KIND_HUU: {a_signed, b_signed} = 2'b00;
      // Low word is the same for any signedness
      mext_pkg::MEXT_KIND_LO:  {a_signed, b_signed} = 2'b00;
      default:                 {a_signed, b_signed} = 2'b00;
    endcase
  end

  assign a_ext   = {a_signed & rs1[`MEXT_XLEN-1], rs1};
  assign b_ext   = {b_signed & rs2[`MEXT_XLEN-1], rs2};
  assign product = a_ext * b_ext;

  // Selected word captured on en
  always_ff @(posedge clk) begin
    if (en) begin
      if (op.mul.kind == mext_pkg::MEXT_KIND_LO) begin
        result <= product[`MEXT_XLEN-1:0];
      end else begin
        result <= product[2*`MEXT_XLEN-1:`MEXT_XLEN];
      end
    end
  end

  // One busy cycle per multiply
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else begin
      busy <= en;
    end
  end

  // No back-to-back multiply launch
  assert property (@(posedge clk) disable iff (!rst_n) busy |-> !en);

endmodule

// File: source/mext_div.sv
`timescale 1ns/1ps

`include "mext_macros.svh"

module mext_div (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  en,
  input  logic [`MEXT_XLEN-1:0] rs1,
  input  logic [`MEXT_XLEN-1:0] rs2,
  input  mext_pkg::mext_op_u    op,
  output logic                  busy,
  output logic [`MEXT_XLEN-1:0] result
);

  // Signed operation in the launch cycle
  logic                  is_signed;
  // Operand signs, qualified by the signed ops
  logic                  rs1_neg;
  logic                  rs2_neg;

  // Values captured on en
  logic                  rs1_neg_q;
  logic                  rs2_neg_q;
  logic [`MEXT_XLEN-1:0] rs1_q;
  mext_pkg::mext_op_u    op_q;

  // Magnitudes fed to the unsigned divider
  logic [`MEXT_XLEN-1:0] dividend_abs;
  logic [`MEXT_XLEN-1:0] divisor_abs;

  // Unsigned divider results
  logic                  div_zero;
  logic [`MEXT_XLEN-1:0] quotient;
  logic [`MEXT_XLEN-1:0] remainder;

  // Sign-corrected results
  logic [`MEXT_XLEN-1:0] quotient_signed;
  logic [`MEXT_XLEN-1:0] remainder_signed;

  assign is_signed = !op.div.is_unsigned;
  assign rs1_neg   = is_signed && rs1[`MEXT_XLEN-1];
  assign rs2_neg   = is_signed && rs2[`MEXT_XLEN-1];

  // Operands may change while the divider iterates
  always_ff @(posedge clk) begin
    if (en) begin
      rs1_neg_q <= rs1_neg;
      rs2_neg_q <= rs2_neg;
      rs1_q     <= rs1;
      op_q      <= op;
    end
  end

  // Most negative value maps onto itself, read as unsigned 2^(XLEN-1)
  assign dividend_abs = rs1_neg ? -rs1 : rs1;
  assign divisor_abs  = rs2_neg ? -rs2 : rs2;

  mext_divu #(
    .WIDTH(`MEXT_XLEN)
  ) mext_divu_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .en       (en),
    .dividend (dividend_abs),
    .divisor  (divisor_abs),
    .busy     (busy),
    .div_zero (div_zero),
    .quotient (quotient),
    .remainder(remainder)
  );

  // Quotient sign follows the operand signs, remainder follows the dividend
  assign quotient_signed  = (rs1_neg_q ^ rs2_neg_q) ? -quotient : quotient;
  assign remainder_signed = rs1_neg_q ? -remainder : remainder;

  // Result select, divide by zero per the RISC-V rules
  always_comb begin
    if (div_zero) begin
      // Remainder is the dividend, quotient is all ones
      result = op_q.div.is_rem ? rs1_q : '1;
    end else if (op_q.div.is_rem) begin
      result = remainder_signed;
    end else begin
      result = quotient_signed;
    end
  end

endmodule

// File: source/mext_divu.sv
`timescale 1ns/1ps

module mext_divu #(
  parameter int WIDTH = 32
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en,
  input  logic [WIDTH-1:0] dividend,
  input  logic [WIDTH-1:0] divisor,
  output logic             busy,
  output logic             div_zero,
  output logic [WIDTH-1:0] quotient,
  output logic [WIDTH-1:0] remainder
);

  // Counter wide enough to hold WIDTH-1
  localparam int CNT_W = $clog2(WIDTH);

  // Partial remainder
  logic [WIDTH-1:0] rem_q;
  // Dividend bits shift out at the top, quotient bits shift in at the bottom
  logic [WIDTH-1:0] quot_q;
  // Divisor held for the whole division
  logic [WIDTH-1:0] divisor_q;
  // Step counter
  logic [CNT_W-1:0] count;

  // Partial remainder with the next dividend bit appended
  logic [WIDTH:0]   shifted;
  // Trial subtraction, one extra bit for the sign
  logic [WIDTH+1:0] diff;
  logic             diff_neg;

  assign shifted  = {rem_q, quot_q[WIDTH-1]};
  assign diff     = {1'b0, shifted} - {2'b00, divisor_q};
  assign diff_neg = diff[WIDTH+1];

  // Control, busy runs WIDTH cycles unless the divisor is zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      div_zero <= 1'b0;
      count    <= '0;
    end else if (en) begin
      // Zero divisor finishes at once
      busy     <= (divisor != '0);
      div_zero <= (divisor == '0);
      count    <= '0;
    end else if (busy) begin
      count <= count + CNT_W'(1);
      // Last step drops busy
      if (count == CNT_W'(WIDTH - 1)) begin
        busy <= 1'b0;
      end
    end
  end

  // Restoring datapath, one quotient bit per cycle
  always_ff @(posedge clk) begin
    if (en) begin
      rem_q     <= '0;
      quot_q    <= dividend;
      divisor_q <= divisor;
    end else if (busy) begin
      if (diff_neg) begin
        // Restore, keep the shifted remainder
        rem_q  <= shifted[WIDTH-1:0];
        quot_q <= {quot_q[WIDTH-2:0], 1'b0};
      end else begin
        // Difference fits below the divisor
        rem_q  <= diff[WIDTH-1:0];
        quot_q <= {quot_q[WIDTH-2:0], 1'b1};
      end
    end
  end

  assign quotient  = quot_q;
  assign remainder = rem_q;

  // Zero divisor never starts the iteration
  assert property (@(posedge clk) disable iff (!rst_n) !(busy && div_zero));

  // Once started, a division is busy for exactly WIDTH cycles
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(busy) |-> busy [*WIDTH] ##1 !busy);

endmodule

// File: source/mext_pkg.sv
package mext_pkg;

  // Multiply kind encodings, funct3[1:0] of the multiply group
  // Low word of the product
  localparam logic [1:0] MEXT_KIND_LO  = 2'b00;
  // High word, signed x signed
  localparam logic [1:0] MEXT_KIND_HSS = 2'b01;
  // High word, signed x unsigned
  localparam logic [1:0] MEXT_KIND_HSU = 2'b10;
  // High word, unsigned x unsigned
  localparam logic [1:0] MEXT_KIND_HUU = 2'b11;

  // Multiply view of funct3
  // Group is 0 for MUL, MULH, MULHSU, MULHU
  typedef struct packed {
    logic       group;
    logic [1:0] kind;
  } mext_mul_op_s;

  // Divide view of funct3
  // Group is 1 for DIV, DIVU, REM, REMU
  typedef struct packed {
    logic group;
    logic is_rem;
    logic is_unsigned;
  } mext_div_op_s;

  // One funct3 word, read as raw bits or through either decoded view
  // Bit 2 is the group bit in both views
  typedef union packed {
    logic [2:0]   raw;
    mext_mul_op_s mul;
    mext_div_op_s div;
  } mext_op_u;

endpackage

// File: source/mext_macros.svh
`ifndef MEXT_MACROS_SVH
`define MEXT_MACROS_SVH

// Operand and result width of the unit
// Matches the RV32 register width
`define MEXT_XLEN 32

// Busy cycles of a division with a nonzero divisor
// One restoring step per quotient bit
`define MEXT_DIV_CYCLES 32

`endif
